/* hdl/la_pkg.sv */
package la_pkg;

    typedef enum logic [2:0] {
        S_IF  = 3'd0,
        S_ID  = 3'd1,
        S_EXE = 3'd2,
        S_MEM = 3'd3,
        S_WB  = 3'd4
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_B    = 3'd1,
        BR_BL   = 3'd2,
        BR_BEQ  = 3'd3,
        BR_BNE  = 3'd4,
        BR_JIRL = 3'd5
    } br_kind_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_LD   = 2'd1,
        MEM_ST   = 2'd2
    } mem_kind_t;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // bits 31:26
    localparam logic [5:0] OP6_ALU   = 6'h00;
    localparam logic [5:0] OP6_LU12I = 6'h05;
    localparam logic [5:0] OP6_LDST  = 6'h0a;
    localparam logic [5:0] OP6_JIRL  = 6'h13;
    localparam logic [5:0] OP6_B     = 6'h14;
    localparam logic [5:0] OP6_BL    = 6'h15;
    localparam logic [5:0] OP6_BEQ   = 6'h16;
    localparam logic [5:0] OP6_BNE   = 6'h17;

    // bits 25:22
    localparam logic [3:0] OP4_REG   = 4'h0;
    localparam logic [3:0] OP4_SHIFT = 4'h1;
    localparam logic [3:0] OP4_LD    = 4'h2;
    localparam logic [3:0] OP4_ST    = 4'h6;
    localparam logic [3:0] OP4_ADDI  = 4'ha;

    // bits 21:20
    localparam logic [1:0] OP2_SHIFT = 2'h0;
    localparam logic [1:0] OP2_REG   = 2'h1;

    // bits 19:15, register group then shift group
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_SRAI = 5'h11;

endpackage

/* hdl/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  logic [31:0]        inst,
    output la_pkg::alu_op_t    alu_op,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic [31:0]        imm,
    output la_pkg::br_kind_t   br_kind,
    output logic [31:0]        br_offs,
    output la_pkg::mem_kind_t  mem_kind,
    output logic               gr_we,
    output logic [4:0]         dest,
    output logic [4:0]         rf_raddr1,
    output logic [4:0]         rf_raddr2
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [4:0]  ui5;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        reg_group;
    logic        shift_group;
    logic        is_known;
    logic        need_ui5;
    logic        need_si12;
    logic        need_si20;
    logic        need_si26;
    logic        src2_is_4;
    logic        src_reg_is_rd;
    logic        no_write;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign ui5      = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};  // offs[25:16] sits in the low bits

    assign reg_group   = op_31_26 == la_pkg::OP6_ALU && op_25_22 == la_pkg::OP4_REG
                         && op_21_20 == la_pkg::OP2_REG;
    assign shift_group = op_31_26 == la_pkg::OP6_ALU && op_25_22 == la_pkg::OP4_SHIFT
                         && op_21_20 == la_pkg::OP2_SHIFT;

    always_comb begin
        alu_op    = la_pkg::ALU_ADD;  // address, link and no-op all add
        br_kind   = la_pkg::BR_NONE;
        mem_kind  = la_pkg::MEM_NONE;
        is_known  = 1'b1;
        need_ui5  = 1'b0;
        need_si12 = 1'b0;
        need_si20 = 1'b0;
        if (reg_group) begin
            case (op_19_15)
                la_pkg::OP5_ADD:  alu_op = la_pkg::ALU_ADD;
                la_pkg::OP5_SUB:  alu_op = la_pkg::ALU_SUB;
                la_pkg::OP5_SLT:  alu_op = la_pkg::ALU_SLT;
                la_pkg::OP5_SLTU: alu_op = la_pkg::ALU_SLTU;
                la_pkg::OP5_NOR:  alu_op = la_pkg::ALU_NOR;
                la_pkg::OP5_AND:  alu_op = la_pkg::ALU_AND;
                la_pkg::OP5_OR:   alu_op = la_pkg::ALU_OR;
                la_pkg::OP5_XOR:  alu_op = la_pkg::ALU_XOR;
                default:          is_known = 1'b0;
            endcase
        end else if (shift_group) begin
            need_ui5 = 1'b1;
            case (op_19_15)
                la_pkg::OP5_SLLI: alu_op = la_pkg::ALU_SLL;
                la_pkg::OP5_SRLI: alu_op = la_pkg::ALU_SRL;
                la_pkg::OP5_SRAI: alu_op = la_pkg::ALU_SRA;
                default:          is_known = 1'b0;
            endcase
        end else if (op_31_26 == la_pkg::OP6_ALU && op_25_22 == la_pkg::OP4_ADDI) begin
            need_si12 = 1'b1;
        end else if (op_31_26 == la_pkg::OP6_LDST && op_25_22 == la_pkg::OP4_LD) begin
            need_si12 = 1'b1;
            mem_kind  = la_pkg::MEM_LD;
        end else if (op_31_26 == la_pkg::OP6_LDST && op_25_22 == la_pkg::OP4_ST) begin
            need_si12 = 1'b1;
            mem_kind  = la_pkg::MEM_ST;
        end else if (op_31_26 == la_pkg::OP6_LU12I && !inst[25]) begin
            need_si20 = 1'b1;
            alu_op    = la_pkg::ALU_LUI;
        end else begin
            case (op_31_26)
                la_pkg::OP6_JIRL: br_kind = la_pkg::BR_JIRL;
                la_pkg::OP6_B:    br_kind = la_pkg::BR_B;
                la_pkg::OP6_BL:   br_kind = la_pkg::BR_BL;
                la_pkg::OP6_BEQ:  br_kind = la_pkg::BR_BEQ;
                la_pkg::OP6_BNE:  br_kind = la_pkg::BR_BNE;
                default:          is_known = 1'b0;
            endcase
        end
    end

    assign src2_is_4     = br_kind == la_pkg::BR_JIRL || br_kind == la_pkg::BR_BL;
    assign need_si26     = br_kind == la_pkg::BR_B || br_kind == la_pkg::BR_BL;
    assign src_reg_is_rd = br_kind == la_pkg::BR_BEQ || br_kind == la_pkg::BR_BNE
                           || mem_kind == la_pkg::MEM_ST;
    assign no_write      = mem_kind == la_pkg::MEM_ST || br_kind == la_pkg::BR_B
                           || br_kind == la_pkg::BR_BEQ || br_kind == la_pkg::BR_BNE;

    assign src1_is_pc  = src2_is_4;  // links are pc + 4
    assign src2_is_imm = need_ui5 | need_si12 | need_si20 | src2_is_4;

    always_comb begin
        if (src2_is_4)
            imm = 32'd4;
        else if (need_si20)
            imm = {i20, 12'b0};
        else if (need_ui5)
            imm = {27'b0, ui5};
        else
            imm = {{20{i12[11]}}, i12};
    end

    assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};

    assign gr_we     = is_known & ~no_write;
    assign dest      = (br_kind == la_pkg::BR_BL) ? 5'd1 : rd;
    assign rf_raddr1 = rj;
    assign rf_raddr2 = src_reg_is_rd ? rd : rk;

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] rf [31:0];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // entry 0 is never written so it is masked on the read side
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  la_pkg::alu_op_t alu_op,
    input  logic [31:0]     alu_src1,
    input  logic [31:0]     alu_src2,
    output logic [31:0]     alu_result
);

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt_signed;
    logic        lt_unsigned;

    assign shamt       = alu_src2[4:0];
    assign sum         = alu_src1 + alu_src2;
    assign diff        = alu_src1 - alu_src2;
    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    always_comb begin
        case (alu_op)
            la_pkg::ALU_ADD:  alu_result = sum;
            la_pkg::ALU_SUB:  alu_result = diff;
            la_pkg::ALU_SLT:  alu_result = {31'b0, lt_signed};
            la_pkg::ALU_SLTU: alu_result = {31'b0, lt_unsigned};
            la_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            la_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            la_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            la_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            la_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            la_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            la_pkg::ALU_SRA:  alu_result = $unsigned($signed(alu_src1) >>> shamt);
            la_pkg::ALU_LUI:  alu_result = alu_src2;  // immediate already shifted by decode
            default:          alu_result = sum;
        endcase
    end

endmodule

/* hdl/mc_control.sv */
`timescale 1ns/1ps

module mc_control (
    input  logic              clk,
    input  logic              reset,
    input  la_pkg::br_kind_t  br_kind,
    input  la_pkg::mem_kind_t mem_kind,
    input  logic              br_taken,
    input  logic [31:0]       br_target,
    output la_pkg::state_t    state,
    output logic [31:0]       pc
);

    la_pkg::state_t next_state;
    logic [31:0]    seq_pc;
    logic           ends_in_id;

    // conditional and plain branches have nothing left to do after decode
    assign ends_in_id = br_kind == la_pkg::BR_B || br_kind == la_pkg::BR_BEQ
                        || br_kind == la_pkg::BR_BNE;

    always_comb begin
        case (state)
            la_pkg::S_IF: next_state = la_pkg::S_ID;
            la_pkg::S_ID: begin
                if (ends_in_id)
                    next_state = la_pkg::S_IF;
                else
                    next_state = la_pkg::S_EXE;
            end
            la_pkg::S_EXE: begin
                if (mem_kind != la_pkg::MEM_NONE)
                    next_state = la_pkg::S_MEM;
                else
                    next_state = la_pkg::S_WB;
            end
            la_pkg::S_MEM: begin
                if (mem_kind == la_pkg::MEM_LD)
                    next_state = la_pkg::S_WB;
                else
                    next_state = la_pkg::S_IF;
            end
            la_pkg::S_WB: next_state = la_pkg::S_IF;
            default:      next_state = la_pkg::S_IF;
        endcase
    end

    assign seq_pc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= la_pkg::S_IF;
            pc    <= la_pkg::RESET_PC;
        end else begin
            state <= next_state;
            if (state == la_pkg::S_ID) begin
                pc <= br_taken ? br_target : seq_pc;  // only edge where the pc moves
            end
        end
    end

endmodule

/* hdl/la_mc_core.sv */
`timescale 1ns/1ps

module la_mc_core (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] inst_sram_rdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] inst_sram_addr,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    la_pkg::state_t    state;
    la_pkg::alu_op_t   alu_op;
    la_pkg::br_kind_t  br_kind;
    la_pkg::mem_kind_t mem_kind;

    logic [31:0] pc;
    logic [31:0] inst_pc;
    logic [31:0] ir;
    logic [31:0] inst;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic        gr_we;
    logic [4:0]  dest;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        rf_we;
    logic [31:0] rf_wdata;
    logic        rj_eq_rd;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] alu_res_q;

    mc_control u_mc_control (
        .clk       (clk),
        .reset     (reset),
        .br_kind   (br_kind),
        .mem_kind  (mem_kind),
        .br_taken  (br_taken),
        .br_target (br_target),
        .state     (state),
        .pc        (pc)
    );

    // fetch data is on the bus during ID, the register holds it from EXE on
    assign inst = (state == la_pkg::S_ID) ? inst_sram_rdata : ir;

    always_ff @(posedge clk) begin
        if (reset)
            ir <= 32'd0;
        else if (state == la_pkg::S_ID)
            ir <= inst_sram_rdata;
    end

    always_ff @(posedge clk) begin
        if (state == la_pkg::S_IF)
            inst_pc <= pc;
        if (state == la_pkg::S_EXE)
            alu_res_q <= alu_result;
    end

    inst_decode u_inst_decode (
        .inst        (inst),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .imm         (imm),
        .br_kind     (br_kind),
        .br_offs     (br_offs),
        .mem_kind    (mem_kind),
        .gr_we       (gr_we),
        .dest        (dest),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign rj_eq_rd = rf_rdata1 == rf_rdata2;

    always_comb begin
        case (br_kind)
            la_pkg::BR_BEQ:                            br_taken = rj_eq_rd;
            la_pkg::BR_BNE:                            br_taken = ~rj_eq_rd;
            la_pkg::BR_B, la_pkg::BR_BL, la_pkg::BR_JIRL: br_taken = 1'b1;
            default:                                   br_taken = 1'b0;
        endcase
    end

    assign br_target = (br_kind == la_pkg::BR_JIRL) ? rf_rdata1 + br_offs : inst_pc + br_offs;

    assign alu_src1 = src1_is_pc ? inst_pc : rf_rdata1;
    assign alu_src2 = src2_is_imm ? imm : rf_rdata2;

    alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    assign inst_sram_addr  = pc;
    assign data_sram_addr  = alu_res_q;
    assign data_sram_wdata = rf_rdata2;  // rd of st.w, still selected from the held instruction
    assign data_sram_we    = state == la_pkg::S_MEM && mem_kind == la_pkg::MEM_ST;

    // load data arrives in WB, one cycle after the MEM address
    assign rf_we    = state == la_pkg::S_WB && gr_we;
    assign rf_wdata = (mem_kind == la_pkg::MEM_LD) ? data_sram_rdata : alu_res_q;

    assign debug_wb_pc       = inst_pc;
    assign debug_wb_rf_we    = {4{rf_we && dest != 5'd0}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* sim/tb_la_mc_core.sv */
`timescale 1ns/1ps

module tb_la_mc_core;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] inst_sram_addr;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_wnum [$];
    logic [31:0] exp_wdata [$];
    int          n_inst;
    int          t_idx;
    int          cycles;
    int          cycle_limit;
    logic [31:0] fetch_addr;
    logic [31:0] load_addr;

    la_mc_core u_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_rdata   (data_sram_rdata),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            fail_run("trace check failed");
        end
    endtask

    task automatic load_stimulus;
        int          fd;
        int          code;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("sim/trace_stimulus.txt", "r");
        if (fd == 0)
            fail_run("cannot open sim/trace_stimulus.txt");
        n_inst = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] == "I") begin
                code = $sscanf(line, "I %h", a);
                imem[n_inst] = a;
                n_inst++;
            end else if (code > 0 && line.len() > 0 && line[0] == "T") begin
                code = $sscanf(line, "T %h %h %h", a, b, c);
                exp_pc.push_back(a);
                exp_wnum.push_back(b[4:0]);
                exp_wdata.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // addresses are sampled mid-cycle and answered just after the next edge
    always @(negedge clk) begin
        fetch_addr = inst_sram_addr - la_pkg::RESET_PC;
        load_addr  = data_sram_addr;
    end

    always @(posedge clk) begin
        if (data_sram_we)
            dmem[data_sram_addr[7:2]] = data_sram_wdata;
        #1;
        if (fetch_addr[31:8] == 24'd0)
            inst_sram_rdata = imem[fetch_addr[7:2]];
        else
            inst_sram_rdata = 32'd0;  // outside the image reads as a no-op
        data_sram_rdata = dmem[load_addr[7:2]];
    end

    always @(negedge clk) begin
        if (reset) begin
            check_value("debug_wb_rf_we", {28'd0, debug_wb_rf_we}, 32'd0);
            check_value("data_sram_we", {31'd0, data_sram_we}, 32'd0);
        end else if (debug_wb_rf_we != 4'd0) begin
            if (t_idx >= exp_pc.size())
                fail_run("register write seen after all expected trace entries were used");
            check_value("debug_wb_rf_we", {28'd0, debug_wb_rf_we}, 32'hf);
            check_value("debug_wb_pc", debug_wb_pc, exp_pc[t_idx]);
            check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum}, {27'd0, exp_wnum[t_idx]});
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata[t_idx]);
            t_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
            fail_run("timeout before all expected trace entries were seen");
    end

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        fetch_addr      = 32'd0;
        load_addr       = 32'd0;
        t_idx           = 0;
        cycles          = 0;
        cycle_limit     = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'd0;
            dmem[i] = 32'h5a00_0000 ^ (i * 32'h0101_0101);
        end
        load_stimulus();
        cycle_limit = 5 * n_inst + exp_pc.size() + 50;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("inst_sram_addr", inst_sram_addr, la_pkg::RESET_PC);
        check_value("data_sram_we", {31'd0, data_sram_we}, 32'd0);
        wait (t_idx == exp_pc.size());
        repeat (10) @(posedge clk);  // room for a stray write to show up
        $display("No errors");
        $finish;
    end

endmodule

/* sim/trace_stimulus.txt */
# I <instruction word>, in order from 1c000000
# T <pc> <register> <value>, expected register writes in order
I 15000004
I 02bff405
I 02801c06
I 001018a7
I 001114c8
I 001218a9
I 001298aa
I 0014188b
I 001498ac
I 0015188d
I 001598ae
I 004090af
I 00448c90
I 00488c91
I 2980800e
I 28808012
I 580008c5
I 02800413
I 580008c6
I 02815414
I 5c0008c6
I 02800815
I 5c0008c5
I 02815414
I 54000c00
I 02800c16
I 50000c00
I 02802417
I 4c000038
I 02801400
I 001020f9
I 50000000
T 1c000000 04 80000000
T 1c000004 05 fffffffd
T 1c000008 06 00000007
T 1c00000c 07 00000004
T 1c000010 08 0000000a
T 1c000014 09 00000001
T 1c000018 0a 00000000
T 1c00001c 0b 7ffffff8
T 1c000020 0c 00000005
T 1c000024 0d 80000007
T 1c000028 0e fffffffa
T 1c00002c 0f ffffffd0
T 1c000030 10 10000000
T 1c000034 11 f0000000
T 1c00003c 12 fffffffa
T 1c000044 13 00000001
T 1c000054 15 00000002
T 1c000060 01 1c000064
T 1c00006c 17 00000009
T 1c000070 18 1c000074
T 1c000064 16 00000003
T 1c000078 19 0000000e

/* vlog.f */
hdl/la_pkg.sv
hdl/inst_decode.sv
hdl/regfile.sv
hdl/alu.sv
hdl/mc_control.sv
hdl/la_mc_core.sv
sim/tb_la_mc_core.sv

/* Makefile */
TOP = tb_la_mc_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
